//--- source/exu_pkg.sv
package exu_pkg;

  // datapath and register file
  localparam int xlen = 32;
  localparam int reg_count = 16;
  localparam int reg_aw = $clog2(reg_count);

  // retire buffer
  localparam int fifo_depth = 4;
  localparam int fifo_aw = $clog2(fifo_depth);

  // data memory, word addressed
  localparam int mem_words = 256;
  localparam int mem_aw = $clog2(mem_words);
  localparam int mem_latency = 2;
  localparam int lat_w = $clog2(mem_latency + 1);

  // machine-mode csr addresses
  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec = 12'h305;
  localparam logic [11:0] csr_mepc = 12'h341;
  localparam logic [11:0] csr_mcause = 12'h342;

  localparam logic [xlen-1:0] ecall_cause = 32'd11;

  typedef enum logic [2:0] {
    op_alu,
    op_branch,
    op_jump,
    op_load,
    op_store,
    op_system,
    op_ebreak
  } exu_opcode_e;

  // sle/sleu are greater-or-equal, used for bge/bgeu
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_sle,
    alu_sleu
  } alu_op_e;

  typedef enum logic [2:0] {
    sys_csrrw,
    sys_csrrs,
    sys_csrrc,
    sys_ecall,
    sys_mret
  } sys_op_e;

endpackage

//--- source/exu_alu.sv
`timescale 1ns/10ps

module exu_alu import exu_pkg::*; (
  input  logic [xlen-1:0] a_i,
  input  logic [xlen-1:0] b_i,
  input  alu_op_e         op_i,
  output logic [xlen-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign lt_s = $signed(a_i) < $signed(b_i);
  assign lt_u = a_i < b_i;

  always_comb begin
    case (op_i)
      alu_add: res_o = a_i + b_i;
      alu_sub: res_o = a_i - b_i;
      alu_and: res_o = a_i & b_i;
      alu_or: res_o = a_i | b_i;
      alu_xor: res_o = a_i ^ b_i;
      alu_sll: res_o = a_i << shamt;
      alu_srl: res_o = a_i >> shamt;
      alu_sra: res_o = $signed(a_i) >>> shamt;
      alu_slt: res_o = {{(xlen - 1){1'b0}}, lt_s};
      alu_sltu: res_o = {{(xlen - 1){1'b0}}, lt_u};
      // greater-or-equal, for bge/bgeu
      alu_sle: res_o = {{(xlen - 1){1'b0}}, ~lt_s};
      alu_sleu: res_o = {{(xlen - 1){1'b0}}, ~lt_u};
      default: res_o = '0;
    endcase
  end

endmodule

//--- source/exu_csr.sv
`timescale 1ns/10ps

module exu_csr import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            we_i,
  input  logic [11:0]     addr_i,
  input  logic [xlen-1:0] wdata_i,
  input  logic            ecall_i,
  input  logic            mret_i,
  input  logic [xlen-1:0] pc_i,
  output logic [xlen-1:0] rdata_o,
  output logic [xlen-1:0] mtvec_o,
  output logic [xlen-1:0] mepc_o
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else if (ecall_i) begin
      mepc <= pc_i;
      mcause <= ecall_cause;
    end else if (mret_i) begin
      // mie <- mpie, then mpie set
      mstatus[3] <= mstatus[7];
      mstatus[7] <= 1'b1;
    end else if (we_i) begin
      case (addr_i)
        csr_mstatus: mstatus <= wdata_i;
        csr_mtvec: mtvec <= wdata_i;
        csr_mepc: mepc <= wdata_i;
        csr_mcause: mcause <= wdata_i;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (addr_i)
      csr_mstatus: rdata_o = mstatus;
      csr_mtvec: rdata_o = mtvec;
      csr_mepc: rdata_o = mepc;
      csr_mcause: rdata_o = mcause;
      default: rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec;
  assign mepc_o = mepc;

endmodule

//--- source/exu_stage.sv
`timescale 1ns/10ps

module exu_stage import exu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // issue side
  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  exu_opcode_e       opcode_i,
  input  alu_op_e           alu_op_i,
  input  sys_op_e           sys_op_i,
  input  logic [reg_aw-1:0] rd_i,
  input  logic [xlen-1:0]   op1_i,
  input  logic [xlen-1:0]   op2_i,
  input  logic [xlen-1:0]   op_j_i,
  input  logic [xlen-1:0]   imm_i,
  input  logic [xlen-1:0]   pc_i,
  // data memory
  output logic              mem_req_o,
  output logic              mem_we_o,
  output logic [xlen-1:0]   mem_addr_o,
  output logic [xlen-1:0]   mem_wdata_o,
  input  logic              mem_ack_i,
  input  logic [xlen-1:0]   mem_rdata_i,
  // completion record
  output logic              done_valid_o,
  output logic [reg_aw-1:0] done_rd_o,
  output logic [xlen-1:0]   done_wdata_o,
  output logic              done_redirect_o,
  output logic [xlen-1:0]   done_npc_o,
  output logic              done_ebreak_o,
  input  logic              fifo_full_i
);

  typedef enum logic [1:0] {st_idle, st_exec, st_mem, st_done} stage_state_e;

  stage_state_e      state;
  exu_opcode_e       opcode_q;
  alu_op_e           alu_op_q;
  sys_op_e           sys_op_q;
  logic [reg_aw-1:0] rd_q;
  logic [xlen-1:0]   op1_q;
  logic [xlen-1:0]   op2_q;
  logic [xlen-1:0]   op_j_q;
  logic [xlen-1:0]   imm_q;
  logic [xlen-1:0]   pc_q;
  logic [xlen-1:0]   load_q;

  logic            accept;
  logic            is_csr;
  logic            branch_taken;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] target;
  logic            csr_we;
  logic            ecall_en;
  logic            mret_en;
  logic [xlen-1:0] csr_wdata;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;

  assign done_valid_o = (state == st_exec || state == st_done) && !fifo_full_i;
  assign issue_ready_o = (state == st_idle) || done_valid_o;
  assign accept = issue_valid_i && issue_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else if (accept) begin
      state <= (opcode_i == op_load || opcode_i == op_store) ? st_mem : st_exec;
    end else if (done_valid_o) begin
      state <= st_idle;
    end else if (state == st_mem && mem_ack_i) begin
      state <= st_done;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      opcode_q <= opcode_i;
      alu_op_q <= alu_op_i;
      sys_op_q <= sys_op_i;
      rd_q <= rd_i;
      op1_q <= op1_i;
      op2_q <= op2_i;
      op_j_q <= op_j_i;
      imm_q <= imm_i;
      pc_q <= pc_i;
    end
    if (state == st_mem && mem_ack_i) begin
      load_q <= mem_rdata_i;
    end
  end

  exu_alu i_alu (
    .a_i  (op1_q),
    .b_i  (op2_q),
    .op_i (alu_op_q),
    .res_o(alu_res)
  );

  assign mem_req_o = (state == st_mem);
  assign mem_we_o = (opcode_q == op_store);
  assign mem_addr_o = op1_q + imm_q;
  assign mem_wdata_o = op2_q;

  // csr side effects land on the push edge, once per op
  assign is_csr = (sys_op_q == sys_csrrw) || (sys_op_q == sys_csrrs) || (sys_op_q == sys_csrrc);
  assign csr_we = done_valid_o && opcode_q == op_system && is_csr;
  assign ecall_en = done_valid_o && opcode_q == op_system && sys_op_q == sys_ecall;
  assign mret_en = done_valid_o && opcode_q == op_system && sys_op_q == sys_mret;

  always_comb begin
    case (sys_op_q)
      sys_csrrs: csr_wdata = csr_rdata | op1_q;
      sys_csrrc: csr_wdata = csr_rdata & ~op1_q;
      default: csr_wdata = op1_q;
    endcase
  end

  exu_csr i_csr (
    .clk    (clk),
    .rst    (rst),
    .we_i   (csr_we),
    .addr_i (imm_q[11:0]),
    .wdata_i(csr_wdata),
    .ecall_i(ecall_en),
    .mret_i (mret_en),
    .pc_i   (pc_q),
    .rdata_o(csr_rdata),
    .mtvec_o(mtvec),
    .mepc_o (mepc)
  );

  assign pc_plus4 = pc_q + 32'd4;
  assign target = op_j_q + imm_q;
  // beq uses sub, so zero means taken
  assign branch_taken = (alu_op_q == alu_sub) ? (alu_res == '0) : (alu_res != '0);

  always_comb begin
    done_rd_o = '0;
    done_wdata_o = '0;
    done_redirect_o = 1'b0;
    done_npc_o = pc_plus4;
    done_ebreak_o = 1'b0;
    case (opcode_q)
      op_alu: begin
        done_rd_o = rd_q;
        done_wdata_o = alu_res;
      end
      op_load: begin
        done_rd_o = rd_q;
        done_wdata_o = load_q;
      end
      op_jump: begin
        done_rd_o = rd_q;
        done_wdata_o = pc_plus4;
        done_redirect_o = 1'b1;
        done_npc_o = target;
      end
      op_branch: begin
        if (branch_taken) begin
          done_redirect_o = 1'b1;
          done_npc_o = target;
        end
      end
      op_system: begin
        if (is_csr) begin
          done_rd_o = rd_q;
          done_wdata_o = csr_rdata;
        end else if (sys_op_q == sys_ecall) begin
          done_redirect_o = 1'b1;
          done_npc_o = mtvec;
        end else if (sys_op_q == sys_mret) begin
          done_redirect_o = 1'b1;
          done_npc_o = mepc;
        end
      end
      op_ebreak: done_ebreak_o = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- source/exu_data_ram.sv
`timescale 1ns/10ps

module exu_data_ram import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_i,
  input  logic            we_i,
  input  logic [xlen-1:0] addr_i,
  input  logic [xlen-1:0] wdata_i,
  output logic            ack_o,
  output logic [xlen-1:0] rdata_o
);

  logic [xlen-1:0]   mem [mem_words];
  logic [lat_w-1:0]  cnt;
  logic [mem_aw-1:0] word_addr;

  // byte address, upper bits ignored
  assign word_addr = addr_i[2 +: mem_aw];

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
      ack_o <= 1'b0;
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= '0;
      end
    end else begin
      ack_o <= 1'b0;
      // req stays up during the ack cycle, so skip it
      if (req_i && !ack_o) begin
        if (cnt == lat_w'(mem_latency - 1)) begin
          cnt <= '0;
          ack_o <= 1'b1;
          if (we_i) begin
            mem[word_addr] <= wdata_i;
          end else begin
            rdata_o <= mem[word_addr];
          end
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- source/exu_retire_fifo.sv
`timescale 1ns/10ps

module exu_retire_fifo import exu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              push_i,
  input  logic [reg_aw-1:0] rd_i,
  input  logic [xlen-1:0]   wdata_i,
  input  logic              redirect_i,
  input  logic [xlen-1:0]   npc_i,
  input  logic              ebreak_i,
  input  logic              pop_i,
  output logic [reg_aw-1:0] rd_o,
  output logic [xlen-1:0]   wdata_o,
  output logic              redirect_o,
  output logic [xlen-1:0]   npc_o,
  output logic              ebreak_o,
  output logic              full_o,
  output logic              empty_o
);

  logic [reg_aw-1:0]  rd_mem [fifo_depth];
  logic [xlen-1:0]    wdata_mem [fifo_depth];
  logic               redirect_mem [fifo_depth];
  logic [xlen-1:0]    npc_mem [fifo_depth];
  logic               ebreak_mem [fifo_depth];
  logic [fifo_aw-1:0] wr_ptr;
  logic [fifo_aw-1:0] rd_ptr;
  logic [fifo_aw:0]   count;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (pop_i && !push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      rd_mem[wr_ptr] <= rd_i;
      wdata_mem[wr_ptr] <= wdata_i;
      redirect_mem[wr_ptr] <= redirect_i;
      npc_mem[wr_ptr] <= npc_i;
      ebreak_mem[wr_ptr] <= ebreak_i;
    end
  end

  // first word fall through
  assign rd_o = rd_mem[rd_ptr];
  assign wdata_o = wdata_mem[rd_ptr];
  assign redirect_o = redirect_mem[rd_ptr];
  assign npc_o = npc_mem[rd_ptr];
  assign ebreak_o = ebreak_mem[rd_ptr];

  assign full_o = (count == (fifo_aw + 1)'(fifo_depth));
  assign empty_o = (count == '0);

endmodule

//--- source/exu_writeback.sv
`timescale 1ns/10ps

module exu_writeback import exu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              empty_i,
  output logic              pop_o,
  input  logic [reg_aw-1:0] rd_i,
  input  logic [xlen-1:0]   wdata_i,
  input  logic              redirect_i,
  input  logic [xlen-1:0]   npc_i,
  input  logic              ebreak_i,
  input  logic              retire_ready_i,
  output logic              retire_valid_o,
  output logic [reg_aw-1:0] retire_rd_o,
  output logic [xlen-1:0]   retire_wdata_o,
  output logic              retire_redirect_o,
  output logic [xlen-1:0]   retire_npc_o,
  output logic              retire_ebreak_o,
  input  logic [reg_aw-1:0] rf_raddr_i,
  output logic [xlen-1:0]   rf_rdata_o
);

  logic [xlen-1:0] rf [reg_count];

  assign pop_o = !empty_i && retire_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid_o <= 1'b0;
      for (int i = 0; i < reg_count; i++) begin
        rf[i] <= '0;
      end
    end else begin
      retire_valid_o <= pop_o;
      // x0 stays zero
      if (pop_o && rd_i != '0) begin
        rf[rd_i] <= wdata_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      retire_rd_o <= rd_i;
      retire_wdata_o <= wdata_i;
      retire_redirect_o <= redirect_i;
      retire_npc_o <= npc_i;
      retire_ebreak_o <= ebreak_i;
    end
  end

  assign rf_rdata_o = rf[rf_raddr_i];

endmodule

//--- source/exu_top.sv
`timescale 1ns/10ps

module exu_top import exu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  exu_opcode_e       opcode_i,
  input  alu_op_e           alu_op_i,
  input  sys_op_e           sys_op_i,
  input  logic [reg_aw-1:0] rd_i,
  input  logic [xlen-1:0]   op1_i,
  input  logic [xlen-1:0]   op2_i,
  input  logic [xlen-1:0]   op_j_i,
  input  logic [xlen-1:0]   imm_i,
  input  logic [xlen-1:0]   pc_i,
  input  logic              retire_ready_i,
  output logic              retire_valid_o,
  output logic [reg_aw-1:0] retire_rd_o,
  output logic [xlen-1:0]   retire_wdata_o,
  output logic              retire_redirect_o,
  output logic [xlen-1:0]   retire_npc_o,
  output logic              retire_ebreak_o,
  input  logic [reg_aw-1:0] rf_raddr_i,
  output logic [xlen-1:0]   rf_rdata_o
);

  logic              mem_req;
  logic              mem_we;
  logic [xlen-1:0]   mem_addr;
  logic [xlen-1:0]   mem_wdata;
  logic              mem_ack;
  logic [xlen-1:0]   mem_rdata;
  logic              done_valid;
  logic [reg_aw-1:0] done_rd;
  logic [xlen-1:0]   done_wdata;
  logic              done_redirect;
  logic [xlen-1:0]   done_npc;
  logic              done_ebreak;
  logic              fifo_full;
  logic              fifo_empty;
  logic              pop;
  logic [reg_aw-1:0] head_rd;
  logic [xlen-1:0]   head_wdata;
  logic              head_redirect;
  logic [xlen-1:0]   head_npc;
  logic              head_ebreak;

  exu_stage i_stage (
    .clk            (clk),
    .rst            (rst),
    .issue_valid_i  (issue_valid_i),
    .issue_ready_o  (issue_ready_o),
    .opcode_i       (opcode_i),
    .alu_op_i       (alu_op_i),
    .sys_op_i       (sys_op_i),
    .rd_i           (rd_i),
    .op1_i          (op1_i),
    .op2_i          (op2_i),
    .op_j_i         (op_j_i),
    .imm_i          (imm_i),
    .pc_i           (pc_i),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_ack_i      (mem_ack),
    .mem_rdata_i    (mem_rdata),
    .done_valid_o   (done_valid),
    .done_rd_o      (done_rd),
    .done_wdata_o   (done_wdata),
    .done_redirect_o(done_redirect),
    .done_npc_o     (done_npc),
    .done_ebreak_o  (done_ebreak),
    .fifo_full_i    (fifo_full)
  );

  exu_data_ram i_data_ram (
    .clk    (clk),
    .rst    (rst),
    .req_i  (mem_req),
    .we_i   (mem_we),
    .addr_i (mem_addr),
    .wdata_i(mem_wdata),
    .ack_o  (mem_ack),
    .rdata_o(mem_rdata)
  );

  exu_retire_fifo i_retire_fifo (
    .clk       (clk),
    .rst       (rst),
    .push_i    (done_valid),
    .rd_i      (done_rd),
    .wdata_i   (done_wdata),
    .redirect_i(done_redirect),
    .npc_i     (done_npc),
    .ebreak_i  (done_ebreak),
    .pop_i     (pop),
    .rd_o      (head_rd),
    .wdata_o   (head_wdata),
    .redirect_o(head_redirect),
    .npc_o     (head_npc),
    .ebreak_o  (head_ebreak),
    .full_o    (fifo_full),
    .empty_o   (fifo_empty)
  );

  exu_writeback i_writeback (
    .clk              (clk),
    .rst              (rst),
    .empty_i          (fifo_empty),
    .pop_o            (pop),
    .rd_i             (head_rd),
    .wdata_i          (head_wdata),
    .redirect_i       (head_redirect),
    .npc_i            (head_npc),
    .ebreak_i         (head_ebreak),
    .retire_ready_i   (retire_ready_i),
    .retire_valid_o   (retire_valid_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wdata_o   (retire_wdata_o),
    .retire_redirect_o(retire_redirect_o),
    .retire_npc_o     (retire_npc_o),
    .retire_ebreak_o  (retire_ebreak_o),
    .rf_raddr_i       (rf_raddr_i),
    .rf_rdata_o       (rf_rdata_o)
  );

endmodule

//--- tb/exu_tb.sv
`timescale 1ns/10ps

module exu_tb import exu_pkg::*; ();

  localparam int n_alu = 200;
  localparam int n_branch = 120;
  localparam int n_mem = 64;
  localparam int n_csr = 25;
  localparam int n_bp = 155;
  localparam int n_ebreak = 1;
  localparam int total_ops = n_alu + n_branch + n_mem + n_csr + n_bp + n_ebreak;
  localparam int watchdog_cycles = total_ops * 10 + 1000;

  typedef struct packed {
    logic [3:0]  rd;
    logic [31:0] wdata;
    logic        redirect;
    logic [31:0] npc;
    logic        ebreak;
  } rec_t;

  logic              clk;
  logic              rst;
  logic              issue_valid_i;
  logic              issue_ready_o;
  exu_opcode_e       opcode_i;
  alu_op_e           alu_op_i;
  sys_op_e           sys_op_i;
  logic [reg_aw-1:0] rd_i;
  logic [xlen-1:0]   op1_i;
  logic [xlen-1:0]   op2_i;
  logic [xlen-1:0]   op_j_i;
  logic [xlen-1:0]   imm_i;
  logic [xlen-1:0]   pc_i;
  logic              retire_ready_i;
  logic              retire_valid_o;
  logic [reg_aw-1:0] retire_rd_o;
  logic [xlen-1:0]   retire_wdata_o;
  logic              retire_redirect_o;
  logic [xlen-1:0]   retire_npc_o;
  logic              retire_ebreak_o;
  logic [reg_aw-1:0] rf_raddr_i;
  logic [xlen-1:0]   rf_rdata_o;

  integer seed = 32'hbe2851e4;
  int     errors = 0;
  int     checks = 0;
  int     retired = 0;
  logic   ready_prev = 1'b1;
  logic   bp_running;

  // reference model state
  rec_t        exp_q[$];
  logic [31:0] regs_m [16];
  logic [31:0] mem_m [256];
  logic [31:0] mstatus_m;
  logic [31:0] mtvec_m;
  logic [31:0] mepc_m;
  logic [31:0] mcause_m;

  alu_op_e     br_ops [6] = '{alu_sub, alu_xor, alu_slt, alu_sltu, alu_sle, alu_sleu};
  logic [11:0] csr_addrs [4] = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause};

  exu_top i_dut (
    .clk              (clk),
    .rst              (rst),
    .issue_valid_i    (issue_valid_i),
    .issue_ready_o    (issue_ready_o),
    .opcode_i         (opcode_i),
    .alu_op_i         (alu_op_i),
    .sys_op_i         (sys_op_i),
    .rd_i             (rd_i),
    .op1_i            (op1_i),
    .op2_i            (op2_i),
    .op_j_i           (op_j_i),
    .imm_i            (imm_i),
    .pc_i             (pc_i),
    .retire_ready_i   (retire_ready_i),
    .retire_valid_o   (retire_valid_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wdata_o   (retire_wdata_o),
    .retire_redirect_o(retire_redirect_o),
    .retire_npc_o     (retire_npc_o),
    .retire_ebreak_o  (retire_ebreak_o),
    .rf_raddr_i       (rf_raddr_i),
    .rf_rdata_o       (rf_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic int rnd_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [31:0] rnd_pc();
    return rnd() & 32'hffff_fffc;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  function automatic logic [31:0] model_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      alu_or: return a | b;
      alu_xor: return a ^ b;
      alu_sll: return a << b[4:0];
      alu_srl: return a >> b[4:0];
      alu_sra: return 32'($signed(a) >>> b[4:0]);
      alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_sle: return ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
      alu_sleu: return (a >= b) ? 32'd1 : 32'd0;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] csr_get(input logic [11:0] addr);
    case (addr)
      csr_mstatus: return mstatus_m;
      csr_mtvec: return mtvec_m;
      csr_mepc: return mepc_m;
      csr_mcause: return mcause_m;
      default: return 32'd0;
    endcase
  endfunction

  task automatic csr_set(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      csr_mstatus: mstatus_m = val;
      csr_mtvec: mtvec_m = val;
      csr_mepc: mepc_m = val;
      csr_mcause: mcause_m = val;
      default: ;
    endcase
  endtask

  // expected record of one accepted op, model state moves in issue order
  task automatic model_op(input exu_opcode_e opc, input alu_op_e aop, input sys_op_e sop,
                          input logic [3:0] rd, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] j, input logic [31:0] imm,
                          input logic [31:0] pc);
    rec_t        r;
    logic [31:0] res;
    logic [31:0] old;
    logic [7:0]  w;
    r = '0;
    r.npc = pc + 32'd4;
    res = model_alu(aop, a, b);
    w = 8'((a + imm) >> 2);
    case (opc)
      op_alu: begin
        r.rd = rd;
        r.wdata = res;
      end
      op_branch: begin
        if ((aop == alu_sub) ? (res == 32'd0) : (res != 32'd0)) begin
          r.redirect = 1'b1;
          r.npc = j + imm;
        end
      end
      op_jump: begin
        r.rd = rd;
        r.wdata = pc + 32'd4;
        r.redirect = 1'b1;
        r.npc = j + imm;
      end
      op_load: begin
        r.rd = rd;
        r.wdata = mem_m[w];
      end
      op_store: mem_m[w] = b;
      op_system: begin
        if (sop == sys_ecall) begin
          r.redirect = 1'b1;
          r.npc = mtvec_m;
          mepc_m = pc;
          mcause_m = 32'd11;
        end else if (sop == sys_mret) begin
          r.redirect = 1'b1;
          r.npc = mepc_m;
          mstatus_m[3] = mstatus_m[7];
          mstatus_m[7] = 1'b1;
        end else begin
          old = csr_get(imm[11:0]);
          r.rd = rd;
          r.wdata = old;
          if (sop == sys_csrrw) csr_set(imm[11:0], a);
          else if (sop == sys_csrrs) csr_set(imm[11:0], old | a);
          else csr_set(imm[11:0], old & ~a);
        end
      end
      op_ebreak: r.ebreak = 1'b1;
      default: ;
    endcase
    if (r.rd != 4'd0) regs_m[r.rd] = r.wdata;
    exp_q.push_back(r);
  endtask

  task automatic issue_op(input exu_opcode_e opc, input alu_op_e aop, input sys_op_e sop,
                          input logic [3:0] rd, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] j, input logic [31:0] imm,
                          input logic [31:0] pc);
    bit taken;
    taken = 1'b0;
    opcode_i = opc;
    alu_op_i = aop;
    sys_op_i = sop;
    rd_i = rd;
    op1_i = a;
    op2_i = b;
    op_j_i = j;
    imm_i = imm;
    pc_i = pc;
    issue_valid_i = 1'b1;
    while (!taken) begin
      @(negedge clk);
      taken = issue_ready_o;
      @(posedge clk);
      #10;
    end
    issue_valid_i = 1'b0;
    model_op(opc, aop, sop, rd, a, b, j, imm, pc);
  endtask

  task automatic gen_alu();
    issue_op(op_alu, alu_op_e'(4'(rnd_below(12))), sys_csrrw, 4'(rnd()), rnd(), rnd(),
             32'd0, 32'd0, rnd_pc());
  endtask

  task automatic gen_branch();
    logic [31:0] a;
    logic [31:0] b;
    a = rnd();
    b = (rnd_below(3) == 0) ? a : rnd();
    issue_op(op_branch, br_ops[rnd_below(6)], sys_csrrw, 4'(rnd()), a, b, rnd_pc(),
             rnd() & 32'h0000_0ffc, rnd_pc());
  endtask

  task automatic gen_jump();
    issue_op(op_jump, alu_add, sys_csrrw, 4'(rnd()), rnd(), rnd(), rnd_pc(),
             rnd() & 32'h0000_0ffc, rnd_pc());
  endtask

  // address op1 + imm lands on one of the first 16 words
  task automatic gen_mem(input bit store);
    logic [31:0] imm;
    logic [31:0] base;
    imm = 32'(rnd_below(64)) * 32'd4;
    base = 32'(rnd_below(16)) * 32'd4 - imm;
    issue_op(store ? op_store : op_load, alu_add, sys_csrrw, 4'(rnd()), base, rnd(), 32'd0,
             imm, rnd_pc());
  endtask

  task automatic gen_sys(input sys_op_e sop, input logic [11:0] addr, input logic [31:0] a);
    issue_op(op_system, alu_add, sop, 4'(rnd()), a, 32'd0, 32'd0, 32'(addr), rnd_pc());
  endtask

  task automatic gen_mixed();
    case (rnd_below(6))
      0: gen_alu();
      1: gen_branch();
      2: gen_jump();
      3: gen_mem(1'b0);
      4: gen_mem(1'b1);
      default: gen_sys(sys_op_e'(3'(rnd_below(3))), csr_addrs[rnd_below(4)], rnd());
    endcase
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("missing retirements: %0d operations never retired", exp_q.size());
      exp_q.delete();
    end
    @(posedge clk);
    #10;
  endtask

  task automatic read_reg(input int idx);
    rf_raddr_i = 4'(idx);
    @(negedge clk);
    check_val($sformatf("rf_rdata_o[%0d]", idx), rf_rdata_o, regs_m[idx]);
    @(posedge clk);
    #10;
  endtask

  task automatic test_done(input string name, input int err_start);
    $display("test %s: %s, %0d errors", name, (errors == err_start) ? "ok" : "failed",
             errors - err_start);
  endtask

  // retire monitor, one record per cycle of retire_valid_o
  always @(negedge clk) begin
    rec_t e;
    if (!rst && retire_valid_o) begin
      if (!ready_prev) begin
        errors++;
        $display("retirement appeared after a cycle with retire_ready_i low");
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("retirement appeared with no operation pending");
      end else begin
        e = exp_q.pop_front();
        retired++;
        check_val("retire_rd_o", 32'(retire_rd_o), 32'(e.rd));
        check_val("retire_wdata_o", retire_wdata_o, e.wdata);
        check_val("retire_redirect_o", 32'(retire_redirect_o), 32'(e.redirect));
        check_val("retire_npc_o", retire_npc_o, e.npc);
        check_val("retire_ebreak_o", 32'(retire_ebreak_o), 32'(e.ebreak));
      end
    end
    ready_prev = retire_ready_i;
  end

  initial begin
    int err_start;
    rst = 1'b1;
    issue_valid_i = 1'b0;
    opcode_i = op_alu;
    alu_op_i = alu_add;
    sys_op_i = sys_csrrw;
    rd_i = '0;
    op1_i = '0;
    op2_i = '0;
    op_j_i = '0;
    imm_i = '0;
    pc_i = '0;
    retire_ready_i = 1'b1;
    rf_raddr_i = '0;
    bp_running = 1'b0;
    for (int i = 0; i < 16; i++) regs_m[i] = 32'd0;
    for (int i = 0; i < 256; i++) mem_m[i] = 32'd0;
    mstatus_m = 32'd0;
    mtvec_m = 32'd0;
    mepc_m = 32'd0;
    mcause_m = 32'd0;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;
    @(negedge clk);
    check_val("issue_ready_o", 32'(issue_ready_o), 32'd1);
    check_val("retire_valid_o", 32'(retire_valid_o), 32'd0);
    check_val("mem_req", 32'(i_dut.mem_req), 32'd0);
    @(posedge clk);
    #10;

    err_start = errors;
    for (int i = 0; i < n_alu; i++) gen_alu();
    wait_drain();
    read_reg(0);
    test_done("alu_ops", err_start);

    err_start = errors;
    for (int i = 0; i < n_branch; i++) begin
      if (rnd_below(4) == 0) gen_jump();
      else gen_branch();
    end
    wait_drain();
    test_done("branch_jump", err_start);

    err_start = errors;
    for (int i = 0; i < 16; i++) gen_mem(1'b1);
    for (int i = 16; i < n_mem; i++) gen_mem(rnd_below(3) == 0);
    wait_drain();
    test_done("load_store", err_start);

    err_start = errors;
    gen_sys(sys_csrrw, csr_mtvec, rnd_pc());
    gen_sys(sys_ecall, csr_mstatus, 32'd0);
    gen_sys(sys_csrrs, csr_mepc, 32'd0);
    gen_sys(sys_csrrs, csr_mcause, 32'd0);
    gen_sys(sys_csrrw, csr_mstatus, rnd());
    gen_sys(sys_mret, csr_mstatus, 32'd0);
    gen_sys(sys_csrrs, csr_mstatus, 32'd0);
    gen_sys(sys_csrrw, csr_mepc, rnd_pc());
    gen_sys(sys_mret, csr_mstatus, 32'd0);
    for (int i = 9; i < n_csr; i++) begin
      gen_sys(sys_op_e'(3'(rnd_below(5))), csr_addrs[rnd_below(4)], rnd());
    end
    wait_drain();
    test_done("csr_system", err_start);

    err_start = errors;
    // fifo fills, the fifth op stays in the stage
    retire_ready_i = 1'b0;
    for (int i = 0; i < 5; i++) gen_alu();
    @(negedge clk);
    @(negedge clk);
    check_val("issue_ready_o", 32'(issue_ready_o), 32'd0);
    @(posedge clk);
    #10;
    retire_ready_i = 1'b1;
    bp_running = 1'b1;
    fork
      begin
        for (int i = 5; i < n_bp; i++) gen_mixed();
        bp_running = 1'b0;
      end
      begin
        int stretch;
        stretch = 0;
        while (bp_running) begin
          if (stretch == 0) begin
            retire_ready_i = ~retire_ready_i;
            stretch = 1 + rnd_below(8);
          end else begin
            stretch--;
          end
          @(posedge clk);
          #10;
        end
        retire_ready_i = 1'b1;
      end
    join
    wait_drain();
    test_done("back_pressure", err_start);

    err_start = errors;
    issue_op(op_ebreak, alu_add, sys_csrrw, 4'(rnd()), rnd(), rnd(), 32'd0, 32'd0, rnd_pc());
    wait_drain();
    for (int i = 0; i < 16; i++) read_reg(i);
    test_done("ebreak_readback", err_start);

    $display("tests: 6, checks: %0d, retired: %0d, errors: %0d", checks, retired, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
source/exu_pkg.sv
source/exu_alu.sv
source/exu_csr.sv
source/exu_stage.sv
source/exu_data_ram.sv
source/exu_retire_fifo.sv
source/exu_writeback.sv
source/exu_top.sv
tb/exu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module exu_tb -f files.f -o exu_sim

out=$(./obj_dir/exu_sim)
echo "$out"

# pass only when the testbench printed the pass line
echo "$out" | grep -q "^RESULT: PASS$"
